/* common/decode_consts.svh */
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// field widths
`define INSN_W      32
`define XLEN_PC     32
`define REG_IDX_W   5
`define ALU_OP_W    5
`define FMT_W       3
`define MEM_ACC_W   2
`define MEM_SZ_W    3
`define IMM_SEL_W   3
`define GRP_W       4

// major opcodes, insn[6:0]
`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111
`define OPC_BRANCH   7'b1100011
`define OPC_LOAD     7'b0000011
`define OPC_STORE    7'b0100011
`define OPC_OP_IMM   7'b0010011
`define OPC_OP       7'b0110011
`define OPC_OP_IMM32 7'b0011011
`define OPC_OP32     7'b0111011
`define OPC_SYSTEM   7'b1110011

// alu operation codes
`define ALU_NONE   5'd0
`define ALU_ADD    5'd1
`define ALU_SUB    5'd2
`define ALU_SLL    5'd3
`define ALU_SRL    5'd4
`define ALU_SRA    5'd5
`define ALU_XOR    5'd6
`define ALU_OR     5'd7
`define ALU_AND    5'd8
`define ALU_LESS   5'd9
`define ALU_LESSU  5'd10
`define ALU_EQUAL  5'd11
`define ALU_NEQ    5'd12
`define ALU_GTE    5'd13
`define ALU_GTEU   5'd14
`define ALU_MUL    5'd15
`define ALU_MULH   5'd16
`define ALU_MULHSU 5'd17
`define ALU_MULHU  5'd18
`define ALU_DIV    5'd19
`define ALU_DIVU   5'd20
`define ALU_REM    5'd21
`define ALU_REMU   5'd22
`define ALU_JUMP   5'd23
`define ALU_IMMVAL 5'd24

// instruction formats
`define FMT_NONE 3'd0
`define FMT_R    3'd1
`define FMT_I    3'd2
`define FMT_S    3'd3
`define FMT_SB   3'd4
`define FMT_U    3'd5
`define FMT_UJ   3'd6

// memory access kind
`define MEM_NONE  2'd0
`define MEM_READ  2'd1
`define MEM_WRITE 2'd2

// memory access size, unsigned variants are loads only
`define MEM_SZ_NONE   3'd0
`define MEM_SZ_BYTE   3'd1
`define MEM_SZ_HALF   3'd2
`define MEM_SZ_WORD   3'd3
`define MEM_SZ_DOUBLE 3'd4
`define MEM_SZ_UBYTE  3'd5
`define MEM_SZ_UHALF  3'd6
`define MEM_SZ_UWORD  3'd7

// immediate select
`define IMM_ZERO   3'd0
`define IMM_I      3'd1
`define IMM_S      3'd2
`define IMM_SB     3'd3
`define IMM_U      3'd4
`define IMM_UJ     3'd5
`define IMM_SHAMT6 3'd6
`define IMM_SHAMT5 3'd7

// opcode groups passed from control to the alu op mapping
`define GRP_NONE     4'd0
`define GRP_LUI      4'd1
`define GRP_AUIPC    4'd2
`define GRP_JAL      4'd3
`define GRP_JALR     4'd4
`define GRP_BRANCH   4'd5
`define GRP_LOAD     4'd6
`define GRP_STORE    4'd7
`define GRP_OP_IMM   4'd8
`define GRP_OP       4'd9
`define GRP_OP_IMM32 4'd10
`define GRP_OP32     4'd11
`define GRP_SYSTEM   4'd12

`endif

/* common/decode_pkg.sv */
`default_nettype none

`include "decode_consts.svh"

package decode_pkg;

	// raw instruction word
	typedef logic [`INSN_W-1:0] insn_t;

	// pc, also used for the decoded immediate
	typedef logic [`XLEN_PC-1:0] pc_t;

	typedef logic [`REG_IDX_W-1:0] reg_idx_t;

	typedef logic [`ALU_OP_W-1:0] alu_op_t;

	typedef logic [`FMT_W-1:0] fmt_t;

	// none, read or write
	typedef logic [`MEM_ACC_W-1:0] mem_acc_t;

	typedef logic [`MEM_SZ_W-1:0] mem_size_t;

	// which immediate layout imm_gen extracts
	typedef logic [`IMM_SEL_W-1:0] imm_sel_t;

endpackage

`default_nettype wire

/* decode/decode_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module decode_ctrl (
	input  decode_pkg::insn_t      i_insn,
	input  logic                   i_func_miss,
	output logic [`GRP_W-1:0]      o_group,
	output decode_pkg::imm_sel_t   o_imm_sel,
	output decode_pkg::fmt_t       o_fmt,
	output logic                   o_reg_write,
	output decode_pkg::mem_acc_t   o_mem_acc,
	output decode_pkg::mem_size_t  o_mem_size,
	output logic                   o_ecall,
	output logic                   o_illegal
);
	import decode_pkg::*;

	logic [6:0] opcode;
	logic [2:0] func3;
	logic       known;
	logic       size_bad;
	logic       is_ecall;
	imm_sel_t   imm_sel;
	fmt_t       fmt;
	logic       reg_write;
	mem_acc_t   mem_acc;
	mem_size_t  mem_size;

	assign opcode = i_insn[6:0];
	assign func3  = i_insn[14:12];

	// opcode classification, independent of the func miss from alu_op_sel
	always_comb begin
		o_group   = `GRP_NONE;
		imm_sel   = `IMM_ZERO;
		fmt       = `FMT_NONE;
		reg_write = 1'b0;
		mem_acc   = `MEM_NONE;
		mem_size  = `MEM_SZ_NONE;
		known     = 1'b1;
		size_bad  = 1'b0;
		is_ecall  = 1'b0;
		case (opcode)
			`OPC_LUI: begin
				o_group   = `GRP_LUI;
				imm_sel   = `IMM_U;
				fmt       = `FMT_U;
				reg_write = 1'b1;
			end
			`OPC_AUIPC: begin
				o_group   = `GRP_AUIPC;
				imm_sel   = `IMM_U;
				fmt       = `FMT_U;
				reg_write = 1'b1;
			end
			`OPC_JAL: begin
				o_group   = `GRP_JAL;
				imm_sel   = `IMM_UJ;
				fmt       = `FMT_UJ;
				reg_write = 1'b1;
			end
			`OPC_JALR: begin
				o_group   = `GRP_JALR;
				imm_sel   = `IMM_I;
				fmt       = `FMT_I;
				reg_write = 1'b1;
			end
			`OPC_BRANCH: begin
				o_group = `GRP_BRANCH;
				imm_sel = `IMM_SB;
				fmt     = `FMT_SB;
			end
			`OPC_LOAD: begin
				o_group   = `GRP_LOAD;
				imm_sel   = `IMM_I;
				fmt       = `FMT_I;
				reg_write = 1'b1;
				mem_acc   = `MEM_READ;
				case (func3)
					3'b000:  mem_size = `MEM_SZ_BYTE;
					3'b001:  mem_size = `MEM_SZ_HALF;
					3'b010:  mem_size = `MEM_SZ_WORD;
					3'b011:  mem_size = `MEM_SZ_DOUBLE;
					3'b100:  mem_size = `MEM_SZ_UBYTE;
					3'b101:  mem_size = `MEM_SZ_UHALF;
					3'b110:  mem_size = `MEM_SZ_UWORD;
					default: size_bad = 1'b1;
				endcase
			end
			`OPC_STORE: begin
				o_group = `GRP_STORE;
				imm_sel = `IMM_S;
				fmt     = `FMT_S;
				mem_acc = `MEM_WRITE;
				// no unsigned stores
				case (func3)
					3'b000:  mem_size = `MEM_SZ_BYTE;
					3'b001:  mem_size = `MEM_SZ_HALF;
					3'b010:  mem_size = `MEM_SZ_WORD;
					3'b011:  mem_size = `MEM_SZ_DOUBLE;
					default: size_bad = 1'b1;
				endcase
			end
			`OPC_OP_IMM: begin
				o_group   = `GRP_OP_IMM;
				// func3 001 and 101 are the shifts
				imm_sel   = (func3[1:0] == 2'b01) ? `IMM_SHAMT6 : `IMM_I;
				fmt       = `FMT_I;
				reg_write = 1'b1;
			end
			`OPC_OP_IMM32: begin
				o_group   = `GRP_OP_IMM32;
				imm_sel   = (func3[1:0] == 2'b01) ? `IMM_SHAMT5 : `IMM_I;
				fmt       = `FMT_I;
				reg_write = 1'b1;
			end
			`OPC_OP: begin
				o_group   = `GRP_OP;
				fmt       = `FMT_R;
				reg_write = 1'b1;
			end
			`OPC_OP32: begin
				o_group   = `GRP_OP32;
				fmt       = `FMT_R;
				reg_write = 1'b1;
			end
			`OPC_SYSTEM: begin
				// only ecall itself, all other bits zero
				if (i_insn[31:7] == 25'd0) begin
					o_group  = `GRP_SYSTEM;
					is_ecall = 1'b1;
				end else begin
					known = 1'b0;
				end
			end
			default: known = 1'b0;
		endcase
		// bad size hides the group so alu_op_sel gives ALU_NONE
		if (size_bad)
			o_group = `GRP_NONE;
	end

	assign o_illegal = !known || size_bad || i_func_miss;

	// illegal words keep only the raw register indices
	always_comb begin
		o_imm_sel   = imm_sel;
		o_fmt       = fmt;
		o_reg_write = reg_write;
		o_mem_acc   = mem_acc;
		o_mem_size  = mem_size;
		o_ecall     = is_ecall;
		if (o_illegal) begin
			o_imm_sel   = `IMM_ZERO;
			o_fmt       = `FMT_NONE;
			o_reg_write = 1'b0;
			o_mem_acc   = `MEM_NONE;
			o_mem_size  = `MEM_SZ_NONE;
			o_ecall     = 1'b0;
		end
	end

	// a detected ecall must never pick up a func miss from alu_op_sel
	always_comb begin
		assert (!(is_ecall && o_illegal));
		assert (!(o_mem_acc == `MEM_WRITE && o_reg_write));
	end

endmodule

`default_nettype wire

/* decode/alu_op_sel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module alu_op_sel (
	input  logic [`GRP_W-1:0]    i_group,
	input  decode_pkg::insn_t    i_insn,
	output decode_pkg::alu_op_t  o_alu_op,
	output logic                 o_word_op,
	output logic                 o_func_miss
);
	import decode_pkg::*;

	logic [2:0] func3;
	logic [6:0] func7;
	alu_op_t    op;
	logic       miss;

	assign func3 = i_insn[14:12];
	assign func7 = i_insn[31:25];

	always_comb begin
		op   = `ALU_NONE;
		miss = 1'b0;
		case (i_group)
			`GRP_JAL:   op = `ALU_JUMP;
			`GRP_LUI,
			`GRP_AUIPC: op = `ALU_IMMVAL;
			// address calculation, size legality is checked in control
			`GRP_LOAD,
			`GRP_STORE: op = `ALU_ADD;
			`GRP_JALR: begin
				op   = `ALU_ADD;
				miss = (func3 != 3'b000);
			end
			`GRP_BRANCH: begin
				case (func3)
					3'b000:  op = `ALU_EQUAL;
					3'b001:  op = `ALU_NEQ;
					3'b100:  op = `ALU_LESS;
					3'b101:  op = `ALU_GTE;
					3'b110:  op = `ALU_LESSU;
					3'b111:  op = `ALU_GTEU;
					default: miss = 1'b1;
				endcase
			end
			`GRP_OP_IMM: begin
				// rv64 shamt is 6 bits so the shift func field is insn[31:26]
				case (func3)
					3'b000: op = `ALU_ADD;
					3'b010: op = `ALU_LESS;
					3'b011: op = `ALU_LESSU;
					3'b100: op = `ALU_XOR;
					3'b110: op = `ALU_OR;
					3'b111: op = `ALU_AND;
					3'b001: begin
						op   = `ALU_SLL;
						miss = (i_insn[31:26] != 6'b000000);
					end
					default: begin
						if (i_insn[31:26] == 6'b000000)
							op = `ALU_SRL;
						else if (i_insn[31:26] == 6'b010000)
							op = `ALU_SRA;
						else
							miss = 1'b1;
					end
				endcase
			end
			`GRP_OP_IMM32: begin
				case ({func7, func3})
					{7'b0000000, 3'b001}: op = `ALU_SLL;
					{7'b0000000, 3'b101}: op = `ALU_SRL;
					{7'b0100000, 3'b101}: op = `ALU_SRA;
					default: begin
						if (func3 == 3'b000)
							op = `ALU_ADD;
						else
							miss = 1'b1;
					end
				endcase
			end
			`GRP_OP: begin
				case ({func7, func3})
					{7'b0000000, 3'b000}: op = `ALU_ADD;
					{7'b0100000, 3'b000}: op = `ALU_SUB;
					{7'b0000000, 3'b001}: op = `ALU_SLL;
					{7'b0000000, 3'b010}: op = `ALU_LESS;
					{7'b0000000, 3'b011}: op = `ALU_LESSU;
					{7'b0000000, 3'b100}: op = `ALU_XOR;
					{7'b0000000, 3'b101}: op = `ALU_SRL;
					{7'b0100000, 3'b101}: op = `ALU_SRA;
					{7'b0000000, 3'b110}: op = `ALU_OR;
					{7'b0000000, 3'b111}: op = `ALU_AND;
					{7'b0000001, 3'b000}: op = `ALU_MUL;
					{7'b0000001, 3'b001}: op = `ALU_MULH;
					{7'b0000001, 3'b010}: op = `ALU_MULHSU;
					{7'b0000001, 3'b011}: op = `ALU_MULHU;
					{7'b0000001, 3'b100}: op = `ALU_DIV;
					{7'b0000001, 3'b101}: op = `ALU_DIVU;
					{7'b0000001, 3'b110}: op = `ALU_REM;
					{7'b0000001, 3'b111}: op = `ALU_REMU;
					default:              miss = 1'b1;
				endcase
			end
			`GRP_OP32: begin
				// word subset, no slt/logic ops and no mulh variants
				case ({func7, func3})
					{7'b0000000, 3'b000}: op = `ALU_ADD;
					{7'b0100000, 3'b000}: op = `ALU_SUB;
					{7'b0000000, 3'b001}: op = `ALU_SLL;
					{7'b0000000, 3'b101}: op = `ALU_SRL;
					{7'b0100000, 3'b101}: op = `ALU_SRA;
					{7'b0000001, 3'b000}: op = `ALU_MUL;
					{7'b0000001, 3'b100}: op = `ALU_DIV;
					{7'b0000001, 3'b101}: op = `ALU_DIVU;
					{7'b0000001, 3'b110}: op = `ALU_REM;
					{7'b0000001, 3'b111}: op = `ALU_REMU;
					default:              miss = 1'b1;
				endcase
			end
			// ecall carries no alu work
			`GRP_SYSTEM: op = `ALU_NONE;
			default:     miss = 1'b1;
		endcase
	end

	assign o_alu_op    = miss ? `ALU_NONE : op;
	assign o_func_miss = miss;
	assign o_word_op   = !miss && (i_group == `GRP_OP_IMM32 || i_group == `GRP_OP32);

endmodule

`default_nettype wire

/* decode/imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module imm_gen (
	input  decode_pkg::imm_sel_t  i_imm_sel,
	input  decode_pkg::insn_t     i_insn,
	input  decode_pkg::pc_t       i_pc,
	output decode_pkg::pc_t       o_imm
);
	import decode_pkg::*;

	pc_t  imm_raw;
	logic add_pc;

	always_comb begin
		imm_raw = '0;
		add_pc  = 1'b0;
		case (i_imm_sel)
			`IMM_I: imm_raw = {{20{i_insn[31]}}, i_insn[31:20]};
			`IMM_S: imm_raw = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
			`IMM_SB: begin
				imm_raw = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25],
					i_insn[11:8], 1'b0};
				add_pc  = 1'b1;
			end
			`IMM_U: begin
				imm_raw = {i_insn[31:12], 12'd0};
				// opcode bit 5 is clear for auipc, set for lui
				add_pc  = !i_insn[5];
			end
			`IMM_UJ: begin
				imm_raw = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20],
					i_insn[30:21], 1'b0};
				add_pc  = 1'b1;
			end
			// shift amounts are zero extended
			`IMM_SHAMT6: imm_raw = {26'd0, i_insn[25:20]};
			`IMM_SHAMT5: imm_raw = {27'd0, i_insn[24:20]};
			default:     imm_raw = '0;
		endcase
	end

	// pc-relative targets are resolved here
	assign o_imm = add_pc ? imm_raw + i_pc : imm_raw;

endmodule

`default_nettype wire

/* decode/decode_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_reg (
	input  logic                   clk,
	input  logic                   i_rst_n,
	input  logic                   i_valid,
	input  decode_pkg::reg_idx_t   i_rd,
	input  decode_pkg::reg_idx_t   i_rs1,
	input  decode_pkg::reg_idx_t   i_rs2,
	input  decode_pkg::pc_t        i_imm,
	input  decode_pkg::alu_op_t    i_alu_op,
	input  logic                   i_word_op,
	input  logic                   i_reg_write,
	input  decode_pkg::fmt_t       i_fmt,
	input  decode_pkg::mem_acc_t   i_mem_acc,
	input  decode_pkg::mem_size_t  i_mem_size,
	input  logic                   i_ecall,
	input  logic                   i_illegal,
	output logic                   o_valid,
	output decode_pkg::reg_idx_t   o_rd,
	output decode_pkg::reg_idx_t   o_rs1,
	output decode_pkg::reg_idx_t   o_rs2,
	output decode_pkg::pc_t        o_imm,
	output decode_pkg::alu_op_t    o_alu_op,
	output logic                   o_word_op,
	output logic                   o_reg_write,
	output decode_pkg::fmt_t       o_fmt,
	output decode_pkg::mem_acc_t   o_mem_acc,
	output decode_pkg::mem_size_t  o_mem_size,
	output logic                   o_ecall,
	output logic                   o_illegal
);
	import decode_pkg::*;

	// control bits, cleared by reset
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_valid     <= 1'b0;
			o_reg_write <= 1'b0;
			o_ecall     <= 1'b0;
		end else begin
			o_valid <= i_valid;
			if (i_valid) begin
				o_reg_write <= i_reg_write;
				o_ecall     <= i_ecall;
			end
		end
	end

	// payload holds its last value while idle
	always_ff @(posedge clk) begin
		if (i_valid) begin
			o_rd       <= i_rd;
			o_rs1      <= i_rs1;
			o_rs2      <= i_rs2;
			o_imm      <= i_imm;
			o_alu_op   <= i_alu_op;
			o_word_op  <= i_word_op;
			o_fmt      <= i_fmt;
			o_mem_acc  <= i_mem_acc;
			o_mem_size <= i_mem_size;
			o_illegal  <= i_illegal;
		end
	end

	// first edge out of reset with no input must not produce a valid
	valid_after_reset: assert property (@(posedge clk)
		(i_rst_n && !$past(i_rst_n) && !i_valid) |=> !o_valid);

endmodule

`default_nettype wire

/* rtl/insn_decoder_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module insn_decoder_top (
	input  logic                   clk,
	input  logic                   i_rst_n,
	input  logic                   i_valid,
	input  decode_pkg::insn_t      i_insn,
	input  decode_pkg::pc_t        i_pc,
	output logic                   o_valid,
	output decode_pkg::reg_idx_t   o_rd,
	output decode_pkg::reg_idx_t   o_rs1,
	output decode_pkg::reg_idx_t   o_rs2,
	output decode_pkg::pc_t        o_imm,
	output decode_pkg::alu_op_t    o_alu_op,
	output logic                   o_word_op,
	output logic                   o_reg_write,
	output decode_pkg::fmt_t       o_fmt,
	output decode_pkg::mem_acc_t   o_mem_acc,
	output decode_pkg::mem_size_t  o_mem_size,
	output logic                   o_ecall,
	output logic                   o_illegal
);
	import decode_pkg::*;

	logic [`GRP_W-1:0] group;
	imm_sel_t          imm_sel;
	fmt_t              fmt;
	logic              reg_write;
	mem_acc_t          mem_acc;
	mem_size_t         mem_size;
	logic              ecall;
	logic              illegal;
	logic              func_miss;
	alu_op_t           alu_op;
	logic              word_op;
	pc_t               imm;

	decode_ctrl i_decode_ctrl (
		.i_insn      (i_insn),
		.i_func_miss (func_miss),
		.o_group     (group),
		.o_imm_sel   (imm_sel),
		.o_fmt       (fmt),
		.o_reg_write (reg_write),
		.o_mem_acc   (mem_acc),
		.o_mem_size  (mem_size),
		.o_ecall     (ecall),
		.o_illegal   (illegal)
	);

	alu_op_sel i_alu_op_sel (
		.i_group     (group),
		.i_insn      (i_insn),
		.o_alu_op    (alu_op),
		.o_word_op   (word_op),
		.o_func_miss (func_miss)
	);

	imm_gen i_imm_gen (
		.i_imm_sel (imm_sel),
		.i_insn    (i_insn),
		.i_pc      (i_pc),
		.o_imm     (imm)
	);

	// register indices go straight from the instruction fields
	decode_reg i_decode_reg (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_valid     (i_valid),
		.i_rd        (i_insn[11:7]),
		.i_rs1       (i_insn[19:15]),
		.i_rs2       (i_insn[24:20]),
		.i_imm       (imm),
		.i_alu_op    (alu_op),
		.i_word_op   (word_op),
		.i_reg_write (reg_write),
		.i_fmt       (fmt),
		.i_mem_acc   (mem_acc),
		.i_mem_size  (mem_size),
		.i_ecall     (ecall),
		.i_illegal   (illegal),
		.o_valid     (o_valid),
		.o_rd        (o_rd),
		.o_rs1       (o_rs1),
		.o_rs2       (o_rs2),
		.o_imm       (o_imm),
		.o_alu_op    (o_alu_op),
		.o_word_op   (o_word_op),
		.o_reg_write (o_reg_write),
		.o_fmt       (o_fmt),
		.o_mem_acc   (o_mem_acc),
		.o_mem_size  (o_mem_size),
		.o_ecall     (o_ecall),
		.o_illegal   (o_illegal)
	);

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic o_clk
);

	// 10 ns period
	initial begin
		o_clk = 1'b0;
	end

	always begin
		#5 o_clk = ~o_clk;
	end

endmodule

`default_nettype wire

/* verif/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
	input  logic        clk,
	input  logic        i_rst_n,
	input  logic        i_valid,
	input  logic        i_out_valid,
	input  logic [4:0]  i_rd,
	input  logic [4:0]  i_rs1,
	input  logic [4:0]  i_rs2,
	input  logic [31:0] i_imm,
	input  logic [4:0]  i_alu_op,
	input  logic        i_word_op,
	input  logic        i_reg_write,
	input  logic [2:0]  i_fmt,
	input  logic [1:0]  i_mem_acc,
	input  logic [2:0]  i_mem_size,
	input  logic        i_ecall,
	input  logic        i_illegal,
	output int          o_value_errs,
	output int          o_timing_errs,
	output int          o_pulses
);

	logic [8*24-1:0] exp_name [0:63];
	// expected fields from rd through illegal
	logic [31:0]     exp_f [0:63][0:11];
	int              n_exp;
	int              value_errs = 0;
	int              timing_errs = 0;
	int              pulses = 0;
	int              reset_cycles = 0;
	logic            prev_valid = 1'b0;

	assign o_value_errs  = value_errs;
	assign o_timing_errs = timing_errs;
	assign o_pulses      = pulses;

	task automatic load_expected();
		int          fd;
		int          cnt;
		int          k;
		string       line;
		logic [8*24-1:0] name;
		logic [31:0] f [0:13];
		n_exp = 0;
		fd = $fopen("verif/decode_vectors.txt", "r");
		if (fd == 0) begin
			$display("checker cannot open verif/decode_vectors.txt");
		end else begin
			while (!$feof(fd) && n_exp < 64) begin
				cnt = $fgets(line, fd);
				cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
					f[9], f[10], f[11], f[12], f[13]);
				if (cnt == 15) begin
					exp_name[n_exp] = name;
					// skip the insn and pc columns
					for (k = 0; k < 12; k++)
						exp_f[n_exp][k] = f[k + 2];
					n_exp++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_field(input logic [8*24-1:0] tname, input string field,
		input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("** Error %0s %0s: expected %h, actual %h", tname, field, exp, act);
			value_errs++;
		end
	endtask

	task automatic compare_outputs(input int idx);
		logic [8*24-1:0] t;
		t = exp_name[idx];
		check_field(t, "rd", exp_f[idx][0], 32'(i_rd));
		check_field(t, "rs1", exp_f[idx][1], 32'(i_rs1));
		check_field(t, "rs2", exp_f[idx][2], 32'(i_rs2));
		check_field(t, "imm", exp_f[idx][3], i_imm);
		check_field(t, "alu_op", exp_f[idx][4], 32'(i_alu_op));
		check_field(t, "word_op", exp_f[idx][5], 32'(i_word_op));
		check_field(t, "reg_write", exp_f[idx][6], 32'(i_reg_write));
		check_field(t, "fmt", exp_f[idx][7], 32'(i_fmt));
		check_field(t, "mem_acc", exp_f[idx][8], 32'(i_mem_acc));
		check_field(t, "mem_size", exp_f[idx][9], 32'(i_mem_size));
		check_field(t, "ecall", exp_f[idx][10], 32'(i_ecall));
		check_field(t, "illegal", exp_f[idx][11], 32'(i_illegal));
	endtask

	initial begin
		load_expected();
	end

	// sample in the middle of the cycle, away from the driving edge
	always @(negedge clk) begin
		if (!i_rst_n) begin
			reset_cycles++;
			if (reset_cycles > 1 && (i_out_valid !== 1'b0 || i_reg_write !== 1'b0
				|| i_ecall !== 1'b0)) begin
				$display("o_valid, o_reg_write or o_ecall not low during reset");
				timing_errs++;
			end
			prev_valid = 1'b0;
		end else begin
			// output valid lags input valid by exactly one edge
			if (i_out_valid !== prev_valid) begin
				$display("** Error valid_timing o_valid: expected %b, actual %b",
					prev_valid, i_out_valid);
				timing_errs++;
			end
			if (i_out_valid === 1'b1) begin
				if (pulses < n_exp)
					compare_outputs(pulses);
				else begin
					$display("o_valid pulse seen after all vectors were consumed");
					timing_errs++;
				end
				pulses++;
			end
			prev_valid = i_valid;
		end
	end

endmodule

`default_nettype wire

/* verif/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;

	logic        clk;
	logic        rst_n;
	logic        valid;
	logic [31:0] insn;
	logic [31:0] pc;

	logic        o_valid;
	logic [4:0]  o_rd;
	logic [4:0]  o_rs1;
	logic [4:0]  o_rs2;
	logic [31:0] o_imm;
	logic [4:0]  o_alu_op;
	logic        o_word_op;
	logic        o_reg_write;
	logic [2:0]  o_fmt;
	logic [1:0]  o_mem_acc;
	logic [2:0]  o_mem_size;
	logic        o_ecall;
	logic        o_illegal;

	int value_errs;
	int timing_errs;
	int pulses;

	logic [31:0] vec_insn [0:63];
	logic [31:0] vec_pc [0:63];
	int          n_vec;
	logic [31:0] rng_state;

	tb_clk_gen u_clk_gen (
		.o_clk (clk)
	);

	insn_decoder_top i_dut (
		.clk         (clk),
		.i_rst_n     (rst_n),
		.i_valid     (valid),
		.i_insn      (insn),
		.i_pc        (pc),
		.o_valid     (o_valid),
		.o_rd        (o_rd),
		.o_rs1       (o_rs1),
		.o_rs2       (o_rs2),
		.o_imm       (o_imm),
		.o_alu_op    (o_alu_op),
		.o_word_op   (o_word_op),
		.o_reg_write (o_reg_write),
		.o_fmt       (o_fmt),
		.o_mem_acc   (o_mem_acc),
		.o_mem_size  (o_mem_size),
		.o_ecall     (o_ecall),
		.o_illegal   (o_illegal)
	);

	tb_checker u_checker (
		.clk          (clk),
		.i_rst_n      (rst_n),
		.i_valid      (valid),
		.i_out_valid  (o_valid),
		.i_rd         (o_rd),
		.i_rs1        (o_rs1),
		.i_rs2        (o_rs2),
		.i_imm        (o_imm),
		.i_alu_op     (o_alu_op),
		.i_word_op    (o_word_op),
		.i_reg_write  (o_reg_write),
		.i_fmt        (o_fmt),
		.i_mem_acc    (o_mem_acc),
		.i_mem_size   (o_mem_size),
		.i_ecall      (o_ecall),
		.i_illegal    (o_illegal),
		.o_value_errs (value_errs),
		.o_timing_errs(timing_errs),
		.o_pulses     (pulses)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// only the instruction and pc columns are needed for driving
	task automatic load_stimulus();
		int          fd;
		int          cnt;
		string       line;
		logic [8*24-1:0] name;
		logic [31:0] f_insn;
		logic [31:0] f_pc;
		n_vec = 0;
		fd = $fopen("verif/decode_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open verif/decode_vectors.txt");
		end else begin
			while (!$feof(fd) && n_vec < 64) begin
				cnt = $fgets(line, fd);
				cnt = $sscanf(line, "%s %h %h", name, f_insn, f_pc);
				if (cnt == 3) begin
					vec_insn[n_vec] = f_insn;
					vec_pc[n_vec]   = f_pc;
					n_vec++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic wait_for_outputs(input int expected, output bit timed_out);
		int cycles;
		timed_out = 1'b1;
		for (cycles = 0; cycles < 500; cycles++) begin
			@(posedge clk);
			if (pulses >= expected) begin
				timed_out = 1'b0;
				break;
			end
		end
	endtask

	initial begin
		int i;
		int g;
		int gap;
		int count_errs;
		bit timed_out;
		rst_n      = 1'b0;
		valid      = 1'b0;
		insn       = 32'd0;
		pc         = 32'd0;
		rng_state  = 32'h04b8_d308;
		count_errs = 0;
		load_stimulus();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		for (i = 0; i < n_vec; i++) begin
			@(posedge clk);
			valid <= 1'b1;
			insn  <= vec_insn[i];
			pc    <= vec_pc[i];
			// 0 to 2 idle cycles, zero gives back-to-back words
			rng_state = xorshift32(rng_state);
			gap = int'(rng_state % 32'd3);
			for (g = 0; g < gap; g++) begin
				@(posedge clk);
				valid <= 1'b0;
			end
		end
		@(posedge clk);
		valid <= 1'b0;

		wait_for_outputs(n_vec, timed_out);
		if (timed_out)
			$display("timeout while waiting for decoded outputs");
		// a few more cycles so stray pulses are counted
		repeat (4) @(posedge clk);
		if (n_vec == 0 || pulses != n_vec) begin
			$display("o_valid pulse count %0d does not match %0d vectors", pulses, n_vec);
			count_errs = 1;
		end
		$display("errors: value %0d, timing %0d, count %0d",
			value_errs, timing_errs, count_errs);
		if (!timed_out && value_errs == 0 && timing_errs == 0 && count_errs == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+common
common/decode_pkg.sv
decode/decode_ctrl.sv
decode/alu_op_sel.sv
decode/imm_gen.sv
decode/decode_reg.sv
rtl/insn_decoder_top.sv
verif/tb_clk_gen.sv
verif/tb_checker.sv
verif/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the decoder testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_top -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
	exit 0
else
	echo "pass message not found in sim.log"
	exit 1
fi

/* verif/decode_vectors.txt */
# name insn pc rd rs1 rs2 imm alu_op word_op reg_write fmt mem_acc mem_size ecall illegal
# all values hex, one decoded instruction per line
lui_x5      123452b7 00001000 05 08 03 12345000 18 0 1 5 0 0 0 0
auipc_neg   fffff097 00002000 01 1f 1f 00001000 18 0 1 5 0 0 0 0
jal_back    ff9ff0ef 00000100 01 1f 19 000000f8 17 0 1 6 0 0 0 0
jalr_ret    00008067 00000104 00 01 00 00000000 01 0 1 2 0 0 0 0
beq_fwd     00208863 00000200 10 01 02 00000210 0b 0 0 4 0 0 0 0
bne_back    fe209ee3 00000300 1d 01 02 000002fc 0c 0 0 4 0 0 0 0
bltu_fwd    0041e463 00000400 08 03 04 00000408 0a 0 0 4 0 0 0 0
add_r       002081b3 00000500 03 01 02 00000000 01 0 1 1 0 0 0 0
sub_r       402081b3 00000504 03 01 02 00000000 02 0 1 1 0 0 0 0
mul_m       027302b3 00000508 05 06 07 00000000 0f 0 1 1 0 0 0 0
divu_m      027352b3 0000050c 05 06 07 00000000 14 0 1 1 0 0 0 0
remw_m      027362bb 00000510 05 06 07 00000000 15 1 1 1 0 0 0 0
subw_r      407302bb 00000514 05 06 07 00000000 02 1 1 1 0 0 0 0
ld_neg      ff813503 00000600 0a 02 18 fffffff8 01 0 1 2 1 4 0 0
lbu_pos     00414503 00000604 0a 02 04 00000004 01 0 1 2 1 5 0 0
sw_pos      00512623 00000608 0c 02 05 0000000c 01 0 0 3 2 3 0 0
sd_neg      fe513823 0000060c 10 02 05 fffffff0 01 0 0 3 2 4 0 0
slli_63     03f09093 00000700 01 01 1f 0000003f 03 0 1 2 0 0 0 0
srai_33     4210d093 00000704 01 01 01 00000021 05 0 1 2 0 0 0 0
sraiw_31    41f0d09b 00000708 01 01 1f 0000001f 05 1 1 2 0 0 0 0
srliw_5     0051d11b 0000070c 02 03 05 00000005 04 1 1 2 0 0 0 0
sltiu_m1    fff2b213 00000710 04 05 1f ffffffff 0a 0 1 2 0 0 0 0
addiw_m2    ffe2821b 00000714 04 05 1e fffffffe 01 1 1 2 0 0 0 0
ecall       00000073 00000800 00 00 00 00000000 00 0 0 0 0 0 1 0
bad_opcode  003100ff 00000804 01 02 03 00000000 00 0 0 0 0 0 0 1
store_f3_5  00515023 00000808 00 02 05 00000000 00 0 0 0 0 0 0 1
op32_f3_2   007322bb 0000080c 05 06 07 00000000 00 0 0 0 0 0 0 1
ebreak      00100073 00000810 00 00 01 00000000 00 0 0 0 0 0 0 1
lui_high    80000137 00000900 02 00 00 80000000 18 0 1 5 0 0 0 0
